//--- pma_testdata.txt
// columns: op adr pl acc data; op 0 write, 1 read expect data, 2 check expect data {ok,dev,cache}
// op 3 write random, 4 read expect random, 5 check against random at, f end; check adr is region
1 1E 0 0 000D000D000D000D
1 1F 0 0 4C4F434B
1 18 0 0 300
1 1A 0 0 0006000600060006
1 10 0 0 2300
1 12 0 0 000F000F000F000F
1 04 0 0 2400
1 06 0 0 001F001F001F001F
1 0A 0 0 0FF00FF00FF00FF0
0 04 0 0 DEAD
1 04 0 0 2400
0 05 0 0 BEEF
1 05 0 0 0
0 1E 0 0 FFFFFFFFFFFFFFFF
1 1E 0 0 000D000D000D000D
2 1 0 0 1011
2 7 3 1 0001
2 7 0 2 1001
2 6 1 2 0000
2 2 0 0 0FF0
0 0F 0 0 554E4C4B
1 0F 0 0 554E4C4B
3 0E 0 0 0
4 0E 0 0 0
0 0F 0 0 4C4F434B
0 0E 0 0 1234
4 0E 0 0 0
5 3 0 0 0
5 3 1 1 0
5 3 2 2 0
5 3 3 0 0
F 0 0 0 0

//--- all.f
pma_pkg.sv
pma_region_table.sv
pma_access_check.sv
pma_unit.sv
tb_pma_unit.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_pma_unit
FILELIST  = all.f
LOG       = sim.log
OBJ_DIR   = obj_dir

.PHONY: help test clean build

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass line"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qxF '** PASS **' $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_pma_unit.sv
// PMA unit testbench
`timescale 1ns/1ps

module tb_pma_unit;
	import pma_pkg::*;

	localparam int MAX_OPS = 64;
	localparam int COLS    = 5; // op, adr or region, pl, acc, data

	logic               clk, rst;
	logic               cs_rgn, cyc, stb, we;
	logic [4:0]         adr;
	bus_data_t          wdat, rdat;
	logic               chk_valid;
	rgn_t               chk_rgn;
	pl_t                chk_pl;
	acc_t               chk_acc;
	logic               chk_done, chk_ok, chk_fault, chk_cache;
	dev_t               chk_dev;
	logic [NUM_RGN-1:0] chk_sel;

	logic [63:0] td [0:MAX_OPS*COLS-1]; // flat table of COLS words per op
	int          n_ops;
	bit          loaded;
	int          errs;
	int          pass_cnt;
	int          fail_cnt;
	integer      seed;
	logic [63:0] rnd_at; // random attribute word for the unlocked region

	pma_unit u_pma_unit (.*);

	always #20 clk = ~clk; // 40 ns period

	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
			errs++;
		end
	endtask

	task automatic idle_inputs();
		cs_rgn    = 1'b0;
		cyc       = 1'b0;
		stb       = 1'b0;
		we        = 1'b0;
		chk_valid = 1'b0;
	endtask

	// expected {ok, dev, cache} from one attribute word in the data file layout
	function automatic logic [15:0] predict(input logic [63:0] attr, input logic [1:0] pl,
			input logic [1:0] acc);
		logic [15:0] e;
		logic        bit_ok;
		logic        ok;
		e = attr[pl*16 +: 16];
		case (acc)
			2'd0:    bit_ok = e[2]; // read
			2'd1:    bit_ok = e[1]; // write
			2'd2:    bit_ok = e[0]; // exec
			default: bit_ok = 1'b0;
		endcase
		ok = bit_ok && (e[11:4] != 8'hFF); // dev ff means no access
		return {3'b0, ok, e[11:4], 3'b0, e[3]};
	endfunction

	// ======================================================================
	// one operation entered and left on a falling edge
	// ======================================================================
	task automatic run_op(input int i);
		logic [63:0] op, a, pl, acc, d;
		logic [15:0] exp_chk;
		int          errs_before;
		op  = td[i*COLS];
		a   = td[i*COLS+1];
		pl  = td[i*COLS+2];
		acc = td[i*COLS+3];
		d   = td[i*COLS+4];
		errs_before = errs;
		exp_chk = (op == 64'd5) ? predict(rnd_at, pl[1:0], acc[1:0]) : d[15:0];
		case (op)
			64'd0, 64'd3, 64'd1, 64'd4: begin // bus transfer
				cs_rgn = 1'b1;
				cyc    = 1'b1;
				stb    = 1'b1;
				we     = (op == 64'd0) || (op == 64'd3);
				adr    = a[4:0];
				wdat   = (op == 64'd3) ? rnd_at : d;
			end
			64'd2, 64'd5: begin
				chk_valid = 1'b1;
				chk_rgn   = a[2:0];
				chk_pl    = pl[1:0];
				chk_acc   = acc_t'(acc[1:0]);
			end
			default: begin
				$display("unknown opcode %0h in test data line %0d", op, i);
				errs++;
			end
		endcase
		@(negedge clk); // results registered one cycle after the request
		if (op == 64'd1)
			compare("rdat", rdat, d);
		else if (op == 64'd4)
			compare("rdat", rdat, rnd_at);
		if (op == 64'd2 || op == 64'd5) begin
			compare("chk_done", chk_done, 1);
			compare("chk_ok", chk_ok, exp_chk[12]);
			compare("chk_fault", chk_fault, !exp_chk[12]);
			compare("chk_dev", chk_dev, exp_chk[11:4]);
			compare("chk_cache", chk_cache, exp_chk[0]);
			compare("chk_sel", chk_sel, 64'd1 << a[2:0]);
		end else begin
			compare("chk_done", chk_done, 0);
		end
		idle_inputs();
		@(negedge clk); // bus reads zero after the idle cycle
		compare("rdat idle", rdat, 0);
		compare("chk_done idle", chk_done, 0);
		if (errs == errs_before)
			pass_cnt++;
		else
			fail_cnt++;
		$display("test %0d op %0h adr %0h: %s", i, op, a, (errs == errs_before) ? "ok" : "FAILED");
	endtask

	// ======================================================================
	// main sequence
	// ======================================================================
	initial begin
		clk     = 1'b0;
		rst     = 1'b1;
		idle_inputs();
		adr     = '0;
		wdat    = '0;
		chk_rgn = '0;
		chk_pl  = '0;
		chk_acc = ACC_READ;
		errs    = 0;
		seed    = 94;
		rnd_at  = {$random(seed), $random(seed)};
		for (int k = 0; k < MAX_OPS*COLS; k++)
			td[k] = 64'hF; // unread lines look like the end marker
		$readmemh("pma_testdata.txt", td);
		n_ops = 0;
		while (n_ops < MAX_OPS && td[n_ops*COLS] != 64'hF)
			n_ops++;
		if (n_ops == 0) begin
			$display("no operations were loaded from the test data file");
			errs++;
		end
		loaded = 1'b1;
		repeat (3) @(negedge clk); // 3 reset cycles
		rst = 1'b0;
		compare("rdat after reset", rdat, 0);
		compare("chk_done after reset", chk_done, 0);
		for (int i = 0; i < n_ops; i++)
			run_op(i);
		$display("tests passed %0d failed %0d, errors %0d", pass_cnt, fail_cnt, errs);
		if (errs == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// watchdog scaled by the number of test lines
	initial begin
		wait (loaded);
		#((n_ops + 10) * 40 * 4);
		$display("timeout: the test sequence did not finish in time");
		$display("** FAIL **");
		$finish;
	end

endmodule

//--- pma_unit.sv
// PMA unit top level
`timescale 1ns/1ps

module pma_unit (
	input  logic                        clk,
	input  logic                        rst,
	// config bus side
	input  logic                        cs_rgn,
	input  logic                        cyc,
	input  logic                        stb,
	input  logic                        we,
	input  logic [4:0]                  adr,
	input  pma_pkg::bus_data_t          wdat,
	output pma_pkg::bus_data_t          rdat,
	// translation check side
	input  logic                        chk_valid,
	input  pma_pkg::rgn_t               chk_rgn,
	input  pma_pkg::pl_t                chk_pl,
	input  pma_pkg::acc_t               chk_acc,
	output logic                        chk_done,
	output logic                        chk_ok,
	output logic                        chk_fault,
	output pma_pkg::dev_t               chk_dev,
	output logic                        chk_cache,
	output logic [pma_pkg::NUM_RGN-1:0] chk_sel
);
	import pma_pkg::*;

	attr_t sel_attr; // region attributes, comb from chk_rgn

	pma_region_table u_table (
		.clk      (clk),
		.rst      (rst),
		.cs_rgn   (cs_rgn),
		.cyc      (cyc),
		.stb      (stb),
		.we       (we),
		.adr      (adr),
		.wdat     (wdat),
		.chk_rgn  (chk_rgn),
		.rdat     (rdat),
		.sel_attr (sel_attr)
	);

	// samples sel_attr with the same request
	pma_access_check u_check (
		.clk       (clk),
		.rst       (rst),
		.chk_valid (chk_valid),
		.chk_pl    (chk_pl),
		.chk_acc   (chk_acc),
		.chk_rgn   (chk_rgn),
		.sel_attr  (sel_attr),
		.chk_done  (chk_done),
		.chk_ok    (chk_ok),
		.chk_fault (chk_fault),
		.chk_dev   (chk_dev),
		.chk_cache (chk_cache),
		.chk_sel   (chk_sel)
	);

endmodule

//--- pma_access_check.sv
// PMA access checker
`timescale 1ns/1ps

module pma_access_check (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        chk_valid,
	input  pma_pkg::pl_t                chk_pl,
	input  pma_pkg::acc_t               chk_acc,
	input  pma_pkg::rgn_t               chk_rgn,
	input  pma_pkg::attr_t              sel_attr,
	output logic                        chk_done,
	output logic                        chk_ok,
	output logic                        chk_fault,
	output pma_pkg::dev_t               chk_dev,
	output logic                        chk_cache,
	output logic [pma_pkg::NUM_RGN-1:0] chk_sel
);
	import pma_pkg::*;

	logic [ATTR_ENT_W-1:0] ent;     // entry for this priv level
	dev_t                  ent_dev;
	logic                  kind_ok; // rwx bit for the access kind
	logic                  pass;
	logic [NUM_RGN-1:0]    onehot;

	// ======================================================================
	// combinational decode
	// ======================================================================
	assign ent     = sel_attr[chk_pl*ATTR_ENT_W +: ATTR_ENT_W];
	assign ent_dev = ent[DEV_LSB +: $bits(dev_t)];

	always_comb begin
		case (chk_acc)
			ACC_READ:  kind_ok = ent[RWX_R];
			ACC_WRITE: kind_ok = ent[RWX_W];
			ACC_EXEC:  kind_ok = ent[RWX_X];
			default:   kind_ok = 1'b0; // unused code, deny
		endcase
	end

	// dev ff overrides any rwx
	assign pass   = kind_ok && (ent_dev != DEV_NONE);
	assign onehot = NUM_RGN'(1) << chk_rgn;

	// ======================================================================
	// result registers
	// ======================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			chk_done  <= 1'b0;
			chk_ok    <= 1'b0;
			chk_fault <= 1'b0;
			chk_sel   <= '0;
		end else begin
			chk_done  <= chk_valid;          // one cycle after request
			chk_ok    <= chk_valid & pass;
			chk_fault <= chk_valid & ~pass;
			chk_sel   <= chk_valid ? onehot : '0;
		end
	end

	// payload, only meaningful with chk_done
	always_ff @(posedge clk) begin
		if (chk_valid) begin
			chk_dev   <= ent_dev;
			chk_cache <= ent[RWX_C];
		end
	end

	// ======================================================================
	// assertions
	// ======================================================================
	assert property (@(posedge clk) disable iff (rst) !(chk_ok && chk_fault))
		else $error("pma_access_check: ok and fault both high");

	assert property (@(posedge clk) disable iff (rst) chk_done |-> $onehot(chk_sel))
		else $error("pma_access_check: chk_sel not one-hot");

endmodule

//--- pma_region_table.sv
// PMA region table
`timescale 1ns/1ps

module pma_region_table (
	input  logic               clk,
	input  logic               rst,
	input  logic               cs_rgn,
	input  logic               cyc,
	input  logic               stb,
	input  logic               we,
	input  logic [4:0]         adr,
	input  pma_pkg::bus_data_t wdat,
	input  pma_pkg::rgn_t      chk_rgn,
	output pma_pkg::bus_data_t rdat,
	output pma_pkg::attr_t     sel_attr
);
	import pma_pkg::*;

	// ======================================================================
	// region storage
	// ======================================================================
	addr_t pmt  [NUM_RGN];
	addr_t cta  [NUM_RGN];
	attr_t at   [NUM_RGN];
	lock_t lock [NUM_RGN];

	logic      xfer;      // bus transfer this cycle
	logic      wr_ok;     // write allowed by lock rule
	rgn_t      adr_rgn;
	fld_t      adr_fld;
	bus_data_t cur_field; // addressed field, zero-extended

	assign adr_rgn = adr[4:2];
	assign adr_fld = adr[1:0];
	assign xfer    = cs_rgn & cyc & stb;
	// lock field always open, rest only while unlocked
	assign wr_ok   = (adr_fld == FLD_LOCK) || (lock[adr_rgn] == UNLK_WORD);

	// reset map
	function automatic addr_t rst_pmt(input int r);
		case (r)
			6:       return 32'h0000_0300; // io
			4:       return 32'h0000_2300; // scratchpad
			1:       return 32'h0000_2400; // dram
			default: return '0;
		endcase
	endfunction

	function automatic attr_t rst_at(input int r);
		case (r)
			7:       return mk_attr(8'h00, 4'hD); // rom, cache-read-exec
			6:       return mk_attr(8'h00, 4'h6); // io, read-write
			5:       return mk_attr(8'h00, 4'h6); // config space
			4:       return mk_attr(8'h00, 4'hF);
			1:       return mk_attr(8'h01, 4'hF); // dram, dev 01
			default: return mk_attr(DEV_NONE, 4'h0); // vacant 3, 2, 0
		endcase
	endfunction

	// one field of one region, zero-extended to bus width
	function automatic bus_data_t fld_read(input rgn_t r, input fld_t f);
		case (f)
			FLD_PMT: return bus_data_t'(pmt[r]);
			FLD_CTA: return bus_data_t'(cta[r]);
			FLD_AT:  return at[r];
			default: return bus_data_t'(lock[r]);
		endcase
	endfunction

	always_comb cur_field = fld_read(adr_rgn, adr_fld);

	// ======================================================================
	// writes
	// ======================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_RGN; i++) begin
				pmt[i]  <= rst_pmt(i);
				cta[i]  <= '0;
				at[i]   <= rst_at(i);
				lock[i] <= LOCK_WORD; // everything starts locked
			end
		end else if (xfer && we && wr_ok) begin
			case (adr_fld)
				FLD_PMT: pmt[adr_rgn]  <= wdat[$bits(addr_t)-1:0];
				FLD_CTA: cta[adr_rgn]  <= wdat[$bits(addr_t)-1:0];
				FLD_AT:  at[adr_rgn]   <= wdat;
				default: lock[adr_rgn] <= wdat[$bits(lock_t)-1:0];
			endcase
		end
	end

	// readback, old value even on a write
	always_ff @(posedge clk) begin
		if (rst)
			rdat <= '0;
		else if (xfer)
			rdat <= cur_field;
		else
			rdat <= '0; // idle bus reads zero
	end

	// attributes for the checker, straight from the tlb region number
	assign sel_attr = at[chk_rgn];

	// ======================================================================
	// assertions
	// ======================================================================
	// locked region ignores writes outside the lock field
	assert property (@(posedge clk) disable iff (rst)
		(xfer && we && !wr_ok) |=>
			(fld_read($past(adr_rgn), $past(adr_fld)) == $past(cur_field)))
		else $error("pma_region_table: locked field changed by write");

	assert property (@(posedge clk) disable iff (rst)
		!xfer |=> (rdat == '0))
		else $error("pma_region_table: rdat nonzero after idle cycle");

endmodule

//--- pma_pkg.sv
// PMA shared definitions
package pma_pkg;

	// ======================================================================
	// widths
	// ======================================================================
	typedef logic [31:0] addr_t;     // pmt / cta address
	typedef logic [63:0] attr_t;     // four 16-bit entries, one per priv level
	typedef logic [31:0] lock_t;     // ascii lock word
	typedef logic [63:0] bus_data_t; // config bus data
	typedef logic [2:0]  rgn_t;      // region number
	typedef logic [1:0]  pl_t;       // privilege level
	typedef logic [7:0]  dev_t;      // device type
	typedef logic [1:0]  fld_t;      // field selector

	localparam int NUM_RGN    = 8;
	localparam int NUM_PL     = 4;
	localparam int ATTR_ENT_W = 16; // bits of one priv-level entry
	localparam int DEV_LSB    = 4;  // dev_type sits at 11..4 in the entry

	// field codes, adr[1:0]
	localparam fld_t FLD_PMT  = 2'd0;
	localparam fld_t FLD_CTA  = 2'd1;
	localparam fld_t FLD_AT   = 2'd2;
	localparam fld_t FLD_LOCK = 2'd3;

	// lock words
	localparam lock_t LOCK_WORD = "LOCK";
	localparam lock_t UNLK_WORD = "UNLK";

	localparam dev_t DEV_NONE = 8'hFF; // no access

	// rwx bit positions inside an entry
	localparam int RWX_C = 3; // cacheable
	localparam int RWX_R = 2;
	localparam int RWX_W = 1;
	localparam int RWX_X = 0;

	// access kind from the translation side
	typedef enum logic [1:0] {
		ACC_READ  = 2'd0,
		ACC_WRITE = 2'd1,
		ACC_EXEC  = 2'd2
	} acc_t;

	// same dev / rwx replicated into all four entries
	function automatic attr_t mk_attr(input dev_t dev, input logic [3:0] rwx);
		attr_t a;
		a = '0;
		for (int i = 0; i < NUM_PL; i++) begin
			a[i*ATTR_ENT_W +: ATTR_ENT_W] = {4'h0, dev, rwx}; // reserved bits zero
		end
		return a;
	endfunction

endpackage
